//--- gat_pkg.sv
package gat_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================

  // Output features per destination node
  localparam int NUM_FEATURE_OUT = 4;

  // Signed integer Wh element
  localparam int WH_DATA_WIDTH = 12;

  // Unsigned attention coefficient, Q0.16
  localparam int ALPHA_WIDTH = 16;

  // Neighbour count, groups hold 1 to 255 entries
  localparam int NUM_NODE_WIDTH = 8;

  // One word of the feature memory
  localparam int FEAT_WIDTH = 32;

  // Accumulator, wide enough for 255 full-scale products
  localparam int ACC_WIDTH = 40;

  // Signed Wh times non-negative alpha
  localparam int PROD_WIDTH = WH_DATA_WIDTH + ALPHA_WIDTH;

  // ==========================================================
  // Types
  // ==========================================================

  typedef logic signed [WH_DATA_WIDTH-1:0] wh_elem_t;
  typedef wh_elem_t [NUM_FEATURE_OUT-1:0] wh_vec_t;

  // First entry of a group carries src_flag and the group size
  typedef struct packed {
    wh_vec_t                   wh;
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      src_flag;
  } wh_entry_t;

  typedef logic [ALPHA_WIDTH-1:0] alpha_t;

  typedef logic signed [PROD_WIDTH-1:0] prod_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;

  typedef logic [NUM_FEATURE_OUT-1:0][FEAT_WIDTH-1:0] feat_vec_t;

endpackage

//--- sync_fifo.sv
module sync_fifo #(
  parameter int  DEPTH     = 8,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t          mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  // Pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Pushes into a full FIFO are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head shows directly, first-word-fall-through
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

endmodule

//--- aggregator.sv
module aggregator
  import gat_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  wh_entry_t wh_head,
  input  logic      wh_empty,
  input  alpha_t    alpha_head,
  input  logic      alpha_empty,
  output logic      pop,
  output feat_vec_t vec,
  output logic      vec_vld,
  input  logic      writer_busy,
  output logic      idle
);

  logic [NUM_NODE_WIDTH-1:0] size_q;
  logic [NUM_NODE_WIDTH-1:0] cnt_q;
  logic [NUM_NODE_WIDTH-1:0] cur_size;
  logic [NUM_NODE_WIDTH-1:0] cur_cnt;
  logic                      entry_first;
  logic                      entry_last;

  logic                      prod_vld;
  logic                      prod_first;
  logic                      prod_last;
  prod_t                     prod_q  [NUM_FEATURE_OUT];

  acc_t                      acc_q   [NUM_FEATURE_OUT];
  acc_t                      acc_sum [NUM_FEATURE_OUT];
  acc_t                      acc_shr [NUM_FEATURE_OUT];

  logic                      take;

  // ==========================================================
  // Pop control and group bookkeeping
  // ==========================================================

  assign take = vec_vld && !writer_busy;

  // A last entry in the product stage already claims the result register
  assign pop = !wh_empty && !alpha_empty && !(prod_vld && prod_last) &&
               (!vec_vld || take);

  assign entry_first = wh_head.src_flag;
  assign cur_size    = entry_first ? wh_head.num_node : size_q;
  assign cur_cnt     = entry_first ? '0 : cnt_q;
  assign entry_last  = ((cur_cnt + 1'b1) == cur_size);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q <= '0;
      cnt_q  <= '0;
    end else if (pop) begin
      size_q <= cur_size;
      cnt_q  <= cur_cnt + 1'b1;
    end
  end

  // ==========================================================
  // Stage 1: products
  // ==========================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_vld   <= 1'b0;
      prod_first <= 1'b0;
      prod_last  <= 1'b0;
    end else begin
      prod_vld   <= pop;
      prod_first <= pop && entry_first;
      prod_last  <= pop && entry_last;
    end
  end

  // Alpha is Q0.16 and unsigned, so widen with a zero before the signed multiply
  always_ff @(posedge clk) begin
    if (pop) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        prod_q[f] <= wh_head.wh[f] * $signed({1'b0, alpha_head});
      end
    end
  end

  // ==========================================================
  // Stage 2: accumulate, shift, ReLU
  // ==========================================================

  always_comb begin
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      // First entry restarts the sum
      acc_sum[f] = prod_first ? acc_t'(prod_q[f]) : acc_q[f] + acc_t'(prod_q[f]);
      acc_shr[f] = acc_sum[f] >>> ALPHA_WIDTH;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_vld) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        acc_q[f] <= acc_sum[f];
      end
    end
    if (prod_vld && prod_last) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        vec[f] <= acc_shr[f][ACC_WIDTH-1] ? '0 : acc_shr[f][FEAT_WIDTH-1:0];
      end
    end
  end

  // Held until the writer takes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vec_vld <= 1'b0;
    end else if (prod_vld && prod_last) begin
      vec_vld <= 1'b1;
    end else if (take) begin
      vec_vld <= 1'b0;
    end
  end

  assign idle = wh_empty && alpha_empty && !prod_vld && !vec_vld && !writer_busy;

endmodule

//--- feature_writer.sv
module feature_writer
  import gat_pkg::*;
#(
  parameter int FEAT_ADDR_W = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  feat_vec_t              vec,
  input  logic                   vec_vld,
  output logic                   busy,
  output logic                   feat_ena,
  output logic [FEAT_ADDR_W-1:0] feat_addr,
  output logic [FEAT_WIDTH-1:0]  feat_din
);

  localparam int IDX_W = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_FEATURE_OUT - 1);

  feat_vec_t              vec_q;
  logic [IDX_W-1:0]       idx_q;
  logic [FEAT_ADDR_W-1:0] addr_q;
  logic                   accept;

  assign accept = vec_vld && !busy;

  // ==========================================================
  // Capture and word walk
  // ==========================================================

  always_ff @(posedge clk) begin
    if (accept) begin
      vec_q <= vec;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      idx_q  <= '0;
      addr_q <= '0;
    end else if (busy) begin
      // One word per cycle, address keeps running across vectors
      addr_q <= addr_q + 1'b1;
      idx_q  <= idx_q + 1'b1;
      if (idx_q == LAST_IDX) begin
        busy <= 1'b0;
      end
    end else if (accept) begin
      busy  <= 1'b1;
      idx_q <= '0;
    end
  end

  // Memory port
  assign feat_ena  = busy;
  assign feat_addr = addr_q;
  assign feat_din  = vec_q[idx_q];

endmodule

//--- gat_aggr_top.sv
module gat_aggr_top
  import gat_pkg::*;
#(
  parameter int WH_DEPTH    = 8,
  parameter int ALPHA_DEPTH = 8,
  parameter int FEAT_ADDR_W = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wh_push,
  input  wh_entry_t              wh_in,
  output logic                   wh_full,
  input  logic                   alpha_push,
  input  alpha_t                 alpha_in,
  output logic                   alpha_full,
  output logic                   feat_ena,
  output logic [FEAT_ADDR_W-1:0] feat_addr,
  output logic [FEAT_WIDTH-1:0]  feat_din,
  output logic                   idle
);

  wh_entry_t wh_head;
  logic      wh_empty;
  alpha_t    alpha_head;
  logic      alpha_empty;
  logic      pop;
  feat_vec_t vec;
  logic      vec_vld;
  logic      writer_busy;

  // ==========================================================
  // Input buffers, popped together
  // ==========================================================

  sync_fifo #(
    .DEPTH     (WH_DEPTH),
    .payload_t (wh_entry_t)
  ) wh_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (wh_push),
    .din   (wh_in),
    .pop   (pop),
    .dout  (wh_head),
    .empty (wh_empty),
    .full  (wh_full)
  );

  sync_fifo #(
    .DEPTH     (ALPHA_DEPTH),
    .payload_t (alpha_t)
  ) alpha_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (alpha_push),
    .din   (alpha_in),
    .pop   (pop),
    .dout  (alpha_head),
    .empty (alpha_empty),
    .full  (alpha_full)
  );

  // ==========================================================
  // Datapath
  // ==========================================================

  aggregator aggregator_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_head     (wh_head),
    .wh_empty    (wh_empty),
    .alpha_head  (alpha_head),
    .alpha_empty (alpha_empty),
    .pop         (pop),
    .vec         (vec),
    .vec_vld     (vec_vld),
    .writer_busy (writer_busy),
    .idle        (idle)
  );

  feature_writer #(
    .FEAT_ADDR_W (FEAT_ADDR_W)
  ) feature_writer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .vec       (vec),
    .vec_vld   (vec_vld),
    .busy      (writer_busy),
    .feat_ena  (feat_ena),
    .feat_addr (feat_addr),
    .feat_din  (feat_din)
  );

endmodule

//--- gat_aggr_checker.sv
module gat_aggr_checker #(
  parameter int FEAT_ADDR_W = 6
) (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   feat_ena,
  input logic [FEAT_ADDR_W-1:0] feat_addr,
  input logic                   wh_push,
  input logic                   wh_full
);

  timeunit 1ns;
  timeprecision 100ps;

  // No memory writes during reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !feat_ena)
    else $error("feat_ena high while reset is active");

  // Addresses run on by one and wrap
  addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (feat_ena && $past(feat_ena)) |->
      (feat_addr == FEAT_ADDR_W'($past(feat_addr) + 1'b1)))
    else $error("feat_addr did not advance by one between writes");

  // Producer must hold off a full Wh FIFO
  no_push_full: assert property (@(posedge clk) wh_push |-> !wh_full)
    else $error("wh_push raised while wh_full is high");

endmodule

bind gat_aggr_top gat_aggr_checker #(
  .FEAT_ADDR_W (FEAT_ADDR_W)
) checker_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .feat_ena  (feat_ena),
  .feat_addr (feat_addr),
  .wh_push   (wh_push),
  .wh_full   (wh_full)
);

//--- tb_gat_aggr.sv
module tb_gat_aggr
  import gat_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W   = 6;
  localparam int NUM_ROWS = 10;

  typedef enum logic [1:0] {A_RAND, A_ZERO, A_ONES} alpha_mode_e;
  typedef enum logic [1:0] {S_RAND, S_NEG, S_POS} sign_mode_e;

  typedef struct packed {
    logic [NUM_NODE_WIDTH-1:0] num_node;
    alpha_mode_e               amode;
    sign_mode_e                smode;
    logic                      burst;
  } row_t;

  // ==========================================================
  // Stimulus table
  // ==========================================================

  // Burst rows push num_node single-entry groups back to back
  row_t rows [NUM_ROWS] = '{
    '{8'd1,   A_RAND, S_RAND, 1'b0},
    '{8'd5,   A_RAND, S_RAND, 1'b0},
    '{8'd255, A_ONES, S_POS,  1'b0},
    '{8'd3,   A_RAND, S_NEG,  1'b0},
    '{8'd4,   A_ZERO, S_RAND, 1'b0},
    '{8'd12,  A_RAND, S_POS,  1'b0},
    '{8'd10,  A_RAND, S_RAND, 1'b1},
    '{8'd2,   A_ONES, S_NEG,  1'b0},
    '{8'd6,   A_RAND, S_RAND, 1'b1},
    '{8'd7,   A_RAND, S_RAND, 1'b0}
  };

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  wh_push;
  wh_entry_t             wh_in;
  logic                  wh_full;
  logic                  alpha_push;
  alpha_t                alpha_in;
  logic                  alpha_full;
  logic                  feat_ena;
  logic [ADDR_W-1:0]     feat_addr;
  logic [FEAT_WIDTH-1:0] feat_din;
  logic                  idle;

  integer                seed = 32'h2902_8537;
  logic [FEAT_WIDTH-1:0] exp_data [$];
  int                    exp_addr  = 0;
  int                    stalls    = 0;
  int                    cycle_cnt = 0;
  int                    cycle_limit;

  gat_aggr_top #(
    .WH_DEPTH    (8),
    .ALPHA_DEPTH (8),
    .FEAT_ADDR_W (ADDR_W)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_push    (wh_push),
    .wh_in      (wh_in),
    .wh_full    (wh_full),
    .alpha_push (alpha_push),
    .alpha_in   (alpha_in),
    .alpha_full (alpha_full),
    .feat_ena   (feat_ena),
    .feat_addr  (feat_addr),
    .feat_din   (feat_din),
    .idle       (idle)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic wh_elem_t make_wh_elem(input sign_mode_e smode);
    int r;
    r = $random(seed);
    case (smode)
      S_NEG:   return {1'b1, r[10:0]};
      S_POS:   return {1'b0, r[10:0]};
      default: return r[11:0];
    endcase
  endfunction

  function automatic alpha_t make_alpha(input alpha_mode_e amode);
    int r;
    r = $random(seed);
    case (amode)
      A_ZERO:  return '0;
      A_ONES:  return '1;
      default: return r[15:0];
    endcase
  endfunction

  // Waits out a full FIFO, then pushes one Wh entry and its alpha together
  task automatic push_entry(input wh_entry_t e, input alpha_t a);
    while (wh_full || alpha_full) begin
      // Same depth, same push and pop strobes, so both fill together
      check_value("wh_full", 32'(wh_full), 32'd1);
      check_value("alpha_full", 32'(alpha_full), 32'd1);
      stalls++;
      wh_push    = 1'b0;
      alpha_push = 1'b0;
      @(negedge clk);
    end
    wh_push    = 1'b1;
    wh_in      = e;
    alpha_push = 1'b1;
    alpha_in   = a;
    @(negedge clk);
  endtask

  // ==========================================================
  // Group generation and reference model
  // ==========================================================

  task automatic run_group(input int size, input alpha_mode_e amode, input sign_mode_e smode);
    longint    sum [NUM_FEATURE_OUT];
    longint    res;
    wh_entry_t e;
    alpha_t    a;
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      sum[f] = 0;
    end
    for (int i = 0; i < size; i++) begin
      a          = make_alpha(amode);
      e.src_flag = (i == 0);
      e.num_node = (i == 0) ? NUM_NODE_WIDTH'(size) : '0;
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        e.wh[f] = make_wh_elem(smode);
        sum[f] += longint'($signed(e.wh[f])) * longint'(a);
      end
      push_entry(e, a);
    end
    // Drop the 16 fraction bits of alpha, then ReLU
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      res = sum[f] >>> 16;
      if (res < 0) begin
        res = 0;
      end
      exp_data.push_back(res[FEAT_WIDTH-1:0]);
    end
  endtask

  // Memory port monitor
  always @(negedge clk) begin
    if (rst_n && feat_ena) begin
      if (exp_data.size() == 0) begin
        $display("Unexpected write at address %0d after every group was written", feat_addr);
        $display("TESTS FAILED");
        $fatal(1, "Extra memory write");
      end else begin
        check_value("feat_din", feat_din, exp_data.pop_front());
        check_value("feat_addr", 32'(feat_addr), exp_addr);
        exp_addr = (exp_addr + 1) % (1 << ADDR_W);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $fatal(1, "Timeout");
    end
  end

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    int groups;
    int entries;
    rst_n      = 1'b0;
    wh_push    = 1'b0;
    wh_in      = '0;
    alpha_push = 1'b0;
    alpha_in   = '0;
    groups     = 0;
    entries    = 0;
    foreach (rows[r]) begin
      entries += int'(rows[r].num_node);
      groups  += rows[r].burst ? int'(rows[r].num_node) : 1;
    end
    cycle_limit = 8 * entries + 10 * groups + 100;

    repeat (2) @(negedge clk);
    check_value("idle in reset", 32'(idle), 32'd1);
    check_value("feat_ena in reset", 32'(feat_ena), 32'd0);
    rst_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].burst) begin
        for (int g = 0; g < int'(rows[r].num_node); g++) begin
          run_group(1, rows[r].amode, rows[r].smode);
        end
      end else begin
        run_group(int'(rows[r].num_node), rows[r].amode, rows[r].smode);
      end
    end
    wh_push    = 1'b0;
    alpha_push = 1'b0;

    // Wait for the last word, the writer frees up one cycle later
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    check_value("idle after drain", 32'(idle), 32'd1);
    check_value("FIFO full reached in bursts", 32'(stalls > 0), 32'd1);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- filelist.f
gat_pkg.sv
sync_fifo.sv
aggregator.sv
feature_writer.sv
gat_aggr_top.sv
gat_aggr_checker.sv
tb_gat_aggr.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tb_gat_aggr
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

COMMON     = --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary -j 0 --Mdir $(OBJ_DIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation ended without a pass"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
